/* hw/conv_param_pkg.sv */
package conv_param_pkg;

  // default buffer geometry, overridden from the top level
  localparam int PARAM_DEPTH_DEF = 16;
  localparam int PARAM_AW_DEF    = 4;

  // parameter word and result width
  localparam int WORD_W = 32;

  typedef logic signed [7:0] tap_t;

  // one host write, last closes the load
  typedef struct packed {
    logic [PARAM_AW_DEF-1:0] addr;
    logic [WORD_W-1:0]       data;
    logic                    last;
  } host_wr_t;

  // bias word layout, shift sits in the low byte
  typedef struct packed {
    logic signed [23:0] value;
    logic [7:0]         shift;
  } bias_field_t;

  // even address holds taps, odd address holds bias and shift
  typedef union packed {
    tap_t [3:0]  weights;
    bias_field_t bias;
  } param_word_u;

  typedef struct packed {
    logic [2:0] kernel;
    tap_t [3:0] act;
  } comp_cmd_t;

  // single-port access, cs without we is a read
  typedef struct packed {
    logic                    cs;
    logic                    we;
    logic [PARAM_AW_DEF-1:0] addr;
    logic [WORD_W-1:0]       wdata;
  } sram_req_t;

endpackage

/* hw/param_sram.sv */
`timescale 1ns/100ps

module param_sram
  import conv_param_pkg::*;
#(
  parameter int PARAM_DEPTH = PARAM_DEPTH_DEF,
  parameter int PARAM_AW    = PARAM_AW_DEF
) (
  input  logic              clk,
  input  sram_req_t         req_i,
  output logic [WORD_W-1:0] rdata_o
);

  logic [WORD_W-1:0]   mem [PARAM_DEPTH];
  logic [PARAM_AW-1:0] idx;

  // request address resized to the array index
  assign idx = PARAM_AW'(req_i.addr);

  // write on cs and we
  always_ff @(posedge clk) begin
    if (req_i.cs && req_i.we) begin
      mem[idx] <= req_i.wdata;
    end
  end

  // read data appears one cycle after the request
  always_ff @(posedge clk) begin
    if (req_i.cs && !req_i.we) begin
      rdata_o <= mem[idx];
    end
  end

endmodule

/* hw/param_host_port.sv */
`timescale 1ns/100ps

module param_host_port
  import conv_param_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      host_req_i,
  input  host_wr_t  host_wr_i,
  output logic      host_ack_o,
  input  logic      load_grant_i,
  output sram_req_t load_wr_o,
  output logic      load_last_o
);

  typedef enum logic [1:0] {
    HP_WAIT  = 2'h0,
    HP_WRITE = 2'h1,
    HP_ACK   = 2'h2
  } hp_state_t;

  hp_state_t state_q;
  hp_state_t state_d;
  host_wr_t  word_q;
  logic      accept;

  // request is taken only once the wrapper hands over the SRAM
  assign accept = (state_q == HP_WAIT) && host_req_i && load_grant_i;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state_q <= HP_WAIT;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      word_q <= host_wr_i;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      HP_WAIT:  if (accept) state_d = HP_WRITE;
      HP_WRITE: state_d = HP_ACK;
      HP_ACK:   if (!host_req_i) state_d = HP_WAIT;
      default:  state_d = HP_WAIT;
    endcase
  end

  // cs alone flags a pending request, cs with we is the write itself
  always_comb begin
    load_wr_o = '0;
    if (state_q == HP_WAIT) begin
      load_wr_o.cs = host_req_i;
    end else if (state_q == HP_WRITE) begin
      load_wr_o.cs    = 1'b1;
      load_wr_o.we    = 1'b1;
      load_wr_o.addr  = word_q.addr;
      load_wr_o.wdata = word_q.data;
    end
  end

  assign load_last_o = (state_q == HP_WRITE) && word_q.last;
  assign host_ack_o  = (state_q == HP_ACK);

endmodule

/* hw/param_buffer_wrapper.sv */
`timescale 1ns/100ps

module param_buffer_wrapper
  import conv_param_pkg::*;
#(
  parameter int PARAM_AW = PARAM_AW_DEF
) (
  input  logic              clk,
  input  logic              rst,
  input  sram_req_t         load_wr_i,
  input  logic              load_last_i,
  output logic              load_grant_o,
  input  sram_req_t         eng_req_i,
  input  logic              eng_busy_i,
  output logic              eng_grant_o,
  output sram_req_t         sram_req_o,
  input  logic [WORD_W-1:0] sram_rdata_i,
  output logic [WORD_W-1:0] eng_rdata_o
);

  typedef enum logic [1:0] {
    ST_IDLE       = 2'h0,
    ST_HOST_LOAD  = 2'h1,
    ST_ENG_ACCESS = 2'h2
  } own_state_t;

  own_state_t state_q;
  own_state_t state_d;
  logic       load_pending;

  assign load_pending = load_wr_i.cs;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (load_pending) state_d = ST_HOST_LOAD;
      end
      ST_HOST_LOAD: begin
        if (load_wr_i.we && load_last_i) state_d = ST_ENG_ACCESS;
      end
      ST_ENG_ACCESS: begin
        // a new load waits for the engine to go quiet
        if (load_pending && !eng_busy_i) state_d = ST_HOST_LOAD;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // grant covers the cycle in which the switch to host load is taken
  assign load_grant_o = (state_q == ST_HOST_LOAD) ||
                        ((state_q == ST_IDLE) && load_pending) ||
                        ((state_q == ST_ENG_ACCESS) && load_pending && !eng_busy_i);

  assign eng_grant_o = (state_q == ST_ENG_ACCESS);

  // only the owner reaches the SRAM
  always_comb begin
    sram_req_o = '0;
    case (state_q)
      ST_HOST_LOAD: begin
        sram_req_o    = load_wr_i;
        sram_req_o.cs = load_wr_i.we;
      end
      ST_ENG_ACCESS: sram_req_o = eng_req_i;
      default:       sram_req_o = '0;
    endcase
  end

  assign eng_rdata_o = (state_q == ST_ENG_ACCESS) ? sram_rdata_i : '0;

endmodule

/* hw/param_dot_engine.sv */
`timescale 1ns/100ps

module param_dot_engine
  import conv_param_pkg::*;
#(
  parameter int PARAM_AW = PARAM_AW_DEF
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              comp_req_i,
  input  comp_cmd_t         comp_cmd_i,
  output logic              comp_ack_o,
  output logic [WORD_W-1:0] comp_result_o,
  input  logic              eng_grant_i,
  output sram_req_t         eng_req_o,
  output logic              eng_busy_o,
  input  logic [WORD_W-1:0] eng_rdata_i
);

  typedef enum logic [2:0] {
    EN_IDLE  = 3'h0,
    EN_RD_W  = 3'h1,
    EN_RD_B  = 3'h2,
    EN_CAP_B = 3'h3,
    EN_MATH  = 3'h4,
    EN_DONE  = 3'h5
  } eng_state_t;

  eng_state_t               state_q;
  eng_state_t               state_d;
  comp_cmd_t                cmd_q;
  param_word_u              w_word_q;
  param_word_u              b_word_q;
  logic [WORD_W-1:0]        result_q;
  logic signed [WORD_W-1:0] dot_sum;
  logic signed [WORD_W-1:0] biased;
  logic [PARAM_AW-1:0]      w_addr;
  logic [PARAM_AW-1:0]      b_addr;
  logic                     accept;

  assign accept = (state_q == EN_IDLE) && comp_req_i && eng_grant_i;

  // kernel k owns words 2k and 2k+1
  assign w_addr = PARAM_AW'({cmd_q.kernel, 1'b0});
  assign b_addr = w_addr + 1'b1;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state_q  <= EN_IDLE;
      result_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == EN_MATH) begin
        result_q <= biased >>> b_word_q.bias.shift;
      end
    end
  end

  // weight word arrives during RD_B, bias word during CAP_B
  always_ff @(posedge clk) begin
    if (accept) cmd_q <= comp_cmd_i;
    if (state_q == EN_RD_B) w_word_q <= eng_rdata_i;
    if (state_q == EN_CAP_B) b_word_q <= eng_rdata_i;
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      EN_IDLE:  if (accept) state_d = EN_RD_W;
      EN_RD_W:  state_d = EN_RD_B;
      EN_RD_B:  state_d = EN_CAP_B;
      EN_CAP_B: state_d = EN_MATH;
      EN_MATH:  state_d = EN_DONE;
      EN_DONE:  if (!comp_req_i) state_d = EN_IDLE;
      default:  state_d = EN_IDLE;
    endcase
  end

  always_comb begin
    eng_req_o = '0;
    if (state_q == EN_RD_W) begin
      eng_req_o.cs   = 1'b1;
      eng_req_o.addr = PARAM_AW_DEF'(w_addr);
    end else if (state_q == EN_RD_B) begin
      eng_req_o.cs   = 1'b1;
      eng_req_o.addr = PARAM_AW_DEF'(b_addr);
    end
  end

  // four signed taps plus sign-extended bias
  always_comb begin
    dot_sum = '0;
    for (int i = 0; i < 4; i++) begin
      dot_sum = dot_sum + $signed(w_word_q.weights[i]) * $signed(cmd_q.act[i]);
    end
    biased = dot_sum + WORD_W'(b_word_q.bias.value);
  end

  // a pending request already holds the SRAM against a new load
  assign eng_busy_o    = (state_q != EN_IDLE) || comp_req_i;
  assign comp_ack_o    = (state_q == EN_DONE);
  assign comp_result_o = result_q;

endmodule

/* hw/param_subsystem_top.sv */
`timescale 1ns/100ps

module param_subsystem_top
  import conv_param_pkg::*;
#(
  parameter int PARAM_DEPTH = PARAM_DEPTH_DEF,
  parameter int PARAM_AW    = PARAM_AW_DEF
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              host_req_i,
  input  host_wr_t          host_wr_i,
  output logic              host_ack_o,
  input  logic              comp_req_i,
  input  comp_cmd_t         comp_cmd_i,
  output logic              comp_ack_o,
  output logic [WORD_W-1:0] comp_result_o
);

  sram_req_t         load_wr;
  logic              load_last;
  logic              load_grant;
  sram_req_t         eng_req;
  logic              eng_grant;
  logic              eng_busy;
  sram_req_t         sram_req;
  logic [WORD_W-1:0] sram_rdata;
  logic [WORD_W-1:0] eng_rdata;

  param_host_port u_param_host_port (
    .clk          (clk),
    .rst          (rst),
    .host_req_i   (host_req_i),
    .host_wr_i    (host_wr_i),
    .host_ack_o   (host_ack_o),
    .load_grant_i (load_grant),
    .load_wr_o    (load_wr),
    .load_last_o  (load_last)
  );

  param_buffer_wrapper #(
    .PARAM_AW (PARAM_AW)
  ) u_param_buffer_wrapper (
    .clk          (clk),
    .rst          (rst),
    .load_wr_i    (load_wr),
    .load_last_i  (load_last),
    .load_grant_o (load_grant),
    .eng_req_i    (eng_req),
    .eng_busy_i   (eng_busy),
    .eng_grant_o  (eng_grant),
    .sram_req_o   (sram_req),
    .sram_rdata_i (sram_rdata),
    .eng_rdata_o  (eng_rdata)
  );

  param_sram #(
    .PARAM_DEPTH (PARAM_DEPTH),
    .PARAM_AW    (PARAM_AW)
  ) u_param_sram (
    .clk     (clk),
    .req_i   (sram_req),
    .rdata_o (sram_rdata)
  );

  param_dot_engine #(
    .PARAM_AW (PARAM_AW)
  ) u_param_dot_engine (
    .clk           (clk),
    .rst           (rst),
    .comp_req_i    (comp_req_i),
    .comp_cmd_i    (comp_cmd_i),
    .comp_ack_o    (comp_ack_o),
    .comp_result_o (comp_result_o),
    .eng_grant_i   (eng_grant),
    .eng_req_o     (eng_req),
    .eng_busy_o    (eng_busy),
    .eng_rdata_i   (eng_rdata)
  );

endmodule

/* tests/param_subsystem_checker.sv */
`timescale 1ns/100ps

module param_subsystem_checker (
  input logic clk,
  input logic rst,
  input logic host_load_i,
  input logic sram_we_i,
  input logic host_req_i,
  input logic host_ack_i,
  input logic comp_req_i,
  input logic comp_ack_i
);

  logic fail_seen = 1'b0;

  // only the host loader may write the parameter SRAM
  a_we_owner: assert property (@(posedge clk) disable iff (rst)
    sram_we_i |-> host_load_i)
    else begin
      $error("SRAM write while the wrapper is not in host load");
      fail_seen = 1'b1;
    end

  a_host_ack_rise: assert property (@(posedge clk) disable iff (rst)
    $rose(host_ack_i) |-> host_req_i)
    else begin
      $error("host ack rose without a host request");
      fail_seen = 1'b1;
    end

  // ack is held for as long as the request stays up
  a_host_ack_hold: assert property (@(posedge clk) disable iff (rst)
    host_ack_i && host_req_i |=> host_ack_i)
    else begin
      $error("host ack dropped before the host request fell");
      fail_seen = 1'b1;
    end

  a_comp_ack_rise: assert property (@(posedge clk) disable iff (rst)
    $rose(comp_ack_i) |-> comp_req_i)
    else begin
      $error("compute ack rose without a compute request");
      fail_seen = 1'b1;
    end

  a_comp_ack_hold: assert property (@(posedge clk) disable iff (rst)
    comp_ack_i && comp_req_i |=> comp_ack_i)
    else begin
      $error("compute ack dropped before the compute request fell");
      fail_seen = 1'b1;
    end

endmodule

/* tests/param_subsystem_tb.sv */
`timescale 1ns/100ps

module param_subsystem_tb
  import conv_param_pkg::*;
();

  localparam int CLK_PERIOD = 8;
  localparam int LOAD_N     = 16;
  localparam int COMP_N     = 8;
  localparam int RAND_N     = 16;
  localparam int RELOAD_N   = 4;
  localparam int EARLY_AT   = 8;
  // generous bound for one host write or one compute handshake
  localparam int HS_CYCLES  = 24;
  localparam int WATCHDOG_CYCLES =
    20 + HS_CYCLES * (LOAD_N + 1 + 2 * COMP_N + RAND_N + RELOAD_N);

  logic              clk;
  logic              rst;
  logic              host_req_i;
  host_wr_t          host_wr_i;
  logic              host_ack_o;
  logic              comp_req_i;
  comp_cmd_t         comp_cmd_i;
  logic              comp_ack_o;
  logic [WORD_W-1:0] comp_result_o;
  logic              assert_failed;

  // host-side copy of the SRAM contents
  logic [31:0] shadow [PARAM_DEPTH_DEF];
  logic [31:0] first_res [COMP_N];
  logic [15:0] lfsr_q = 16'd91;

  // rows are {addr, data, last} with taps at even and bias at odd addresses
  host_wr_t load_tab [LOAD_N] = '{
    {4'h0, 32'h04030201, 1'b0}, {4'h1, 32'h00000A00, 1'b0},
    {4'h2, 32'h0403FEFF, 1'b0}, {4'h3, 32'hFFFF9C04, 1'b0},
    {4'h4, 32'hC040807F, 1'b0}, {4'h5, 32'h0003E81F, 1'b0},
    {4'h6, 32'h08F02010, 1'b0}, {4'h7, 32'hFFFFFF00, 1'b0},
    {4'h8, 32'h7F7F7F7F, 1'b0}, {4'h9, 32'h12345604, 1'b0},
    {4'hA, 32'h80808080, 1'b0}, {4'hB, 32'hFF00001F, 1'b0},
    {4'hC, 32'h01FF01FF, 1'b0}, {4'hD, 32'h00000502, 1'b0},
    {4'hE, 32'hE0203040, 1'b0}, {4'hF, 32'hFFFE0C08, 1'b1}
  };

  // rewrites kernels 2 and 5 only
  host_wr_t reload_tab [RELOAD_N] = '{
    {4'h4, 32'h11F022EE, 1'b0}, {4'h5, 32'hFFFFF003, 1'b0},
    {4'hA, 32'h05FB05FB, 1'b0}, {4'hB, 32'h00010000, 1'b1}
  };

  // {kernel, act3..act0}
  comp_cmd_t comp_tab [COMP_N] = '{
    {3'd0, 32'h02FF0305}, {3'd1, 32'h80017F10},
    {3'd2, 32'h01020304}, {3'd3, 32'hF0F0F0F0},
    {3'd4, 32'h7F7F7F7F}, {3'd5, 32'h7F017F01},
    {3'd6, 32'hFF00FF00}, {3'd7, 32'hC0D0E0F0}
  };

  param_subsystem_top u_param_subsystem_top (
    .clk           (clk),
    .rst           (rst),
    .host_req_i    (host_req_i),
    .host_wr_i     (host_wr_i),
    .host_ack_o    (host_ack_o),
    .comp_req_i    (comp_req_i),
    .comp_cmd_i    (comp_cmd_i),
    .comp_ack_o    (comp_ack_o),
    .comp_result_o (comp_result_o)
  );

  bind param_buffer_wrapper param_subsystem_checker u_param_subsystem_checker (
    .clk         (clk),
    .rst         (rst),
    .host_load_i (state_q == ST_HOST_LOAD),
    .sram_we_i   (sram_req_o.cs && sram_req_o.we),
    .host_req_i  (u_param_host_port.host_req_i),
    .host_ack_i  (u_param_host_port.host_ack_o),
    .comp_req_i  (u_param_dot_engine.comp_req_i),
    .comp_ack_i  (u_param_dot_engine.comp_ack_o)
  );

  assign assert_failed =
    u_param_subsystem_top.u_param_buffer_wrapper.u_param_subsystem_checker.fail_seen;

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: a handshake did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $fatal(1, "simulation hung");
  end

  // any failed checker assertion ends the run
  initial begin
    wait (assert_failed);
    $display("a bound handshake or SRAM ownership assertion failed");
    $display("CHECKS FAILED");
    $fatal(1, "assertion failure");
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("error: %s expected %h got %h", name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // dot product of signed taps plus sign-extended bias then arithmetic shift
  function automatic logic [31:0] expected_result(input comp_cmd_t cmd);
    logic [31:0] w_word;
    logic [31:0] b_word;
    int          acc;
    int          i;
    w_word = shadow[2 * int'(cmd.kernel)];
    b_word = shadow[2 * int'(cmd.kernel) + 1];
    acc = 0;
    for (i = 0; i < 4; i++) begin
      acc += int'($signed(w_word[8*i +: 8])) * int'($signed(cmd.act[i]));
    end
    acc += int'($signed(b_word[31:8]));
    return 32'(acc >>> int'(b_word[7:0]));
  endfunction

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic host_write(input host_wr_t wr);
    @(posedge clk);
    host_wr_i  <= wr;
    host_req_i <= 1'b1;
    @(posedge clk);
    while (!host_ack_o) @(posedge clk);
    shadow[wr.addr] = wr.data;
    host_req_i <= 1'b0;
    @(posedge clk);
    while (host_ack_o) @(posedge clk);
  endtask

  task automatic start_compute(input comp_cmd_t cmd);
    @(posedge clk);
    comp_cmd_i <= cmd;
    comp_req_i <= 1'b1;
  endtask

  task automatic finish_compute(output logic [31:0] res);
    @(posedge clk);
    while (!comp_ack_o) @(posedge clk);
    res = comp_result_o;
    comp_req_i <= 1'b0;
    @(posedge clk);
    while (comp_ack_o) @(posedge clk);
  endtask

  task automatic compute_and_check(input comp_cmd_t cmd, output logic [31:0] res);
    start_compute(cmd);
    finish_compute(res);
    check_value("comp_result_o", expected_result(cmd), res);
  endtask

  initial begin
    logic [31:0] res;
    logic [31:0] act;
    comp_cmd_t   cmd;
    int          i;
    host_req_i = 1'b0;
    host_wr_i  = '0;
    comp_req_i = 1'b0;
    comp_cmd_i = '0;
    rst        = 1'b1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_value("host_ack_o", 32'(0), 32'(host_ack_o));
    check_value("comp_ack_o", 32'(0), 32'(comp_ack_o));
    check_value("comp_result_o", 32'(0), comp_result_o);

    // full load while a compute request raised partway has to wait
    for (i = 0; i < LOAD_N; i++) begin
      if (i == EARLY_AT) start_compute(comp_tab[0]);
      host_write(load_tab[i]);
      if (i >= EARLY_AT && i < LOAD_N - 1) begin
        check_value("comp_ack_o", 32'(0), 32'(comp_ack_o));
      end
    end
    finish_compute(res);
    check_value("comp_result_o", expected_result(comp_tab[0]), res);

    for (i = 0; i < COMP_N; i++) begin
      compute_and_check(comp_tab[i], res);
      first_res[i] = res;
    end

    for (i = 0; i < RAND_N; i++) begin
      draw_bits(32, act);
      cmd.kernel = 3'(i % 8);
      cmd.act    = act;
      compute_and_check(cmd, res);
    end

    // engine is idle here so the reload takes the SRAM back
    for (i = 0; i < RELOAD_N; i++) begin
      host_write(reload_tab[i]);
    end
    for (i = 0; i < COMP_N; i++) begin
      compute_and_check(comp_tab[i], res);
      if (comp_tab[i].kernel != 3'd2 && comp_tab[i].kernel != 3'd5) begin
        check_value("comp_result_o", first_res[i], res);
      end
    end

    // assertions sampled on the final edge report before this point
    @(negedge clk);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* project.f */
hw/conv_param_pkg.sv
hw/param_sram.sv
hw/param_host_port.sv
hw/param_buffer_wrapper.sv
hw/param_dot_engine.sv
hw/param_subsystem_top.sv
tests/param_subsystem_checker.sv
tests/param_subsystem_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := param_subsystem_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
